//--- logic/csi_tx_defines.svh
/*
 * image size, colour bar values, CSI-2 data type codes
 * and the RAW10 payload length of one line
 */
`ifndef CSI_TX_DEFINES_SVH
`define CSI_TX_DEFINES_SVH

`define IMAGE_X_SIZE 16
`define IMAGE_Y_SIZE 4
`define WORD_COUNT (`IMAGE_X_SIZE * 10 / 8)  // RAW10 bytes per line
`define BAR_WIDTH (`IMAGE_X_SIZE / 4)

// {r, g, b}, 10 bits each
`define COLOR_BAR0 30'h000993fc  // blue
`define COLOR_BAR1 30'h3fcff000  // yellow
`define COLOR_BAR2 30'h3fc003fc  // pink
`define COLOR_BAR3 30'h0cccc0cc  // green

`define DT_FRAME_START 6'h00
`define DT_FRAME_END 6'h01
`define DT_RAW10 6'h2B

`endif

//--- logic/csi_tx_pkg.sv
/*
 * types shared by the byte clock transmit path:
 * event kinds from the pattern source and the
 * 32-bit packet header word with its short and long views
 */
package csi_tx_pkg;

    typedef enum logic [1:0] {
        EV_FRAME_START = 2'd0,
        EV_LINE_START  = 2'd1,
        EV_FRAME_END   = 2'd2
    } csi_event_e;

    // byte 0 is data id, byte 3 is ecc
    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] frame_number;
        logic [7:0]  data_id;  // vc in [7:6], data type in [5:0]
    } csi_short_hdr_t;

    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] word_count;
        logic [7:0]  data_id;
    } csi_long_hdr_t;

    typedef union packed {
        csi_short_hdr_t short_view;
        csi_long_hdr_t  long_view;
    } csi_header_u;

endpackage

//--- logic/colorbar_source.sv
/*
 * colour bar pattern source
 * walks one frame line by line, issues frame and line events
 * and the Bayer component of a four bar test image
 */
`include "csi_tx_defines.svh"

module colorbar_source (
    input  logic                   clock_camera_byte,
    input  logic                   reset_camera_byte_n,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   frame_done_o,
    output logic                   event_valid_o,
    output csi_tx_pkg::csi_event_e event_kind_o,
    input  logic                   event_ready_i,
    output logic                   pixel_valid_o,
    output logic [9:0]             pixel_data_o,
    input  logic                   pixel_ready_i,
    input  logic                   frame_end_sent_i
);
    import csi_tx_pkg::*;

    localparam int X_W = $clog2(`IMAGE_X_SIZE);
    localparam int Y_W = $clog2(`IMAGE_Y_SIZE);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_FS   = 3'd1;
    localparam logic [2:0] ST_LS   = 3'd2;
    localparam logic [2:0] ST_PIX  = 3'd3;
    localparam logic [2:0] ST_FE   = 3'd4;
    localparam logic [2:0] ST_WAIT = 3'd5;  // frame end still in the framer

    logic [2:0]     phase;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic [X_W-1:0] bar_idx;
    logic [29:0]    bar_color;
    logic           last_x;
    logic           last_y;

    assign last_x  = (x == X_W'(`IMAGE_X_SIZE - 1));
    assign last_y  = (y == Y_W'(`IMAGE_Y_SIZE - 1));
    assign bar_idx = x / X_W'(`BAR_WIDTH);

    always_comb begin
        case (bar_idx)
            X_W'(0): bar_color = `COLOR_BAR0;
            X_W'(1): bar_color = `COLOR_BAR1;
            X_W'(2): bar_color = `COLOR_BAR2;
            default: bar_color = `COLOR_BAR3;
        endcase
    end

    // odd lines r/g, even lines g/b
    assign pixel_data_o = y[0] ? (x[0] ? bar_color[29:20] : bar_color[19:10])
                               : (x[0] ? bar_color[19:10] : bar_color[9:0]);

    assign event_valid_o = (phase == ST_FS) || (phase == ST_LS) || (phase == ST_FE);
    assign pixel_valid_o = (phase == ST_PIX);
    assign busy_o        = (phase != ST_IDLE);
    assign frame_done_o  = (phase == ST_WAIT) && frame_end_sent_i;

    always_comb begin
        case (phase)
            ST_FS:   event_kind_o = EV_FRAME_START;
            ST_FE:   event_kind_o = EV_FRAME_END;
            default: event_kind_o = EV_LINE_START;
        endcase
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            phase <= ST_IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (phase)
                ST_IDLE: if (start_i) phase <= ST_FS;
                ST_FS:   if (event_ready_i) phase <= ST_LS;
                ST_LS:   if (event_ready_i) phase <= ST_PIX;
                ST_PIX: begin
                    if (pixel_ready_i) begin
                        if (last_x) begin
                            x <= '0;
                            if (last_y) begin
                                y     <= '0;
                                phase <= ST_FE;
                            end else begin
                                y     <= y + 1'b1;
                                phase <= ST_LS;
                            end
                        end else begin
                            x <= x + 1'b1;
                        end
                    end
                end
                ST_FE:   if (event_ready_i) phase <= ST_WAIT;
                ST_WAIT: if (frame_end_sent_i) phase <= ST_IDLE;
                default: phase <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- logic/raw10_packer.sv
/*
 * RAW10 packer
 * collects four 10-bit pixels, then offers five bytes:
 * upper 8 bits of pixels 0..3, then the four low bit pairs
 */
module raw10_packer (
    input  logic       clock_camera_byte,
    input  logic       reset_camera_byte_n,
    input  logic       pixel_valid_i,
    input  logic [9:0] pixel_data_i,
    output logic       pixel_ready_o,
    output logic       payload_valid_o,
    output logic [7:0] payload_byte_o,
    input  logic       payload_ready_i
);

    logic [39:0] pix_sr;    // pixel 0 in [9:0] once full
    logic [1:0]  pix_cnt;
    logic        full;
    logic [2:0]  byte_idx;
    logic        pixel_xfer;
    logic        payload_xfer;

    assign pixel_ready_o   = !full;
    assign payload_valid_o = full;
    assign pixel_xfer      = pixel_valid_i && pixel_ready_o;
    assign payload_xfer    = payload_valid_o && payload_ready_i;

    always_comb begin
        case (byte_idx)
            3'd0:    payload_byte_o = pix_sr[9:2];
            3'd1:    payload_byte_o = pix_sr[19:12];
            3'd2:    payload_byte_o = pix_sr[29:22];
            3'd3:    payload_byte_o = pix_sr[39:32];
            default: payload_byte_o = {pix_sr[31:30], pix_sr[21:20], pix_sr[11:10], pix_sr[1:0]};
        endcase
    end

    always_ff @(posedge clock_camera_byte) begin
        if (pixel_xfer) begin
            pix_sr <= {pixel_data_i, pix_sr[39:10]};
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            pix_cnt  <= '0;
            full     <= 1'b0;
            byte_idx <= '0;
        end else begin
            if (pixel_xfer) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == 2'd3) begin
                    full     <= 1'b1;
                    byte_idx <= '0;
                end
            end
            if (payload_xfer) begin
                if (byte_idx == 3'd4) begin
                    full     <= 1'b0;  // group done, take next four
                    byte_idx <= '0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/packet_header_gen.sv
/*
 * packet header builder
 * frame number counter, short/long header fill
 * and the CSI-2 6-bit Hamming ECC over the first 24 bits
 */
`include "csi_tx_defines.svh"

module packet_header_gen (
    input  logic                    clock_camera_byte,
    input  logic                    reset_camera_byte_n,
    input  logic                    event_valid_i,
    input  csi_tx_pkg::csi_event_e  event_kind_i,
    output logic                    event_ready_o,
    output logic                    header_valid_o,
    output csi_tx_pkg::csi_header_u header_word_o,
    output logic                    header_long_o,
    input  logic                    header_ready_i
);
    import csi_tx_pkg::*;

    logic [15:0] frame_count;
    logic [15:0] frame_count_next;
    csi_header_u next_word;
    logic        event_xfer;

    function automatic logic [7:0] csi_ecc(input logic [23:0] d);
        logic [7:0] p;
        p[0] = ^(d & 24'hF12CB7);
        p[1] = ^(d & 24'hF2555B);
        p[2] = ^(d & 24'h749A6D);
        p[3] = ^(d & 24'hB8E38E);
        p[4] = ^(d & 24'hDF03F0);
        p[5] = ^(d & 24'hEFFC00);
        p[7:6] = 2'b00;
        return p;
    endfunction

    assign event_ready_o    = !header_valid_o;
    assign event_xfer       = event_valid_i && event_ready_o;
    assign frame_count_next = frame_count + 16'd1;

    always_comb begin
        next_word = '0;  // vc 0
        case (event_kind_i)
            EV_FRAME_START: begin
                next_word.short_view.data_id      = {2'b00, `DT_FRAME_START};
                next_word.short_view.frame_number = frame_count_next;
            end
            EV_LINE_START: begin
                next_word.long_view.data_id    = {2'b00, `DT_RAW10};
                next_word.long_view.word_count = 16'(`WORD_COUNT);
            end
            default: begin
                next_word.short_view.data_id      = {2'b00, `DT_FRAME_END};
                next_word.short_view.frame_number = frame_count;
            end
        endcase
        next_word.short_view.ecc = csi_ecc(next_word[23:0]);
    end

    always_ff @(posedge clock_camera_byte) begin
        if (event_xfer) begin
            header_word_o <= next_word;
            header_long_o <= (event_kind_i == EV_LINE_START);
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            header_valid_o <= 1'b0;
            frame_count    <= '0;
        end else begin
            if (event_xfer) begin
                header_valid_o <= 1'b1;
                if (event_kind_i == EV_FRAME_START) frame_count <= frame_count_next;
            end else if (header_ready_i) begin
                header_valid_o <= 1'b0;
            end
        end
    end

endmodule

//--- logic/csi_packet_framer.sv
/*
 * packet framer
 * sends the four header bytes, then the line payload for long
 * packets, as one byte stream with a last marker per packet
 */
`include "csi_tx_defines.svh"

module csi_packet_framer (
    input  logic                    clock_camera_byte,
    input  logic                    reset_camera_byte_n,
    input  logic                    header_valid_i,
    input  csi_tx_pkg::csi_header_u header_word_i,
    input  logic                    header_long_i,
    output logic                    header_ready_o,
    input  logic                    payload_valid_i,
    input  logic [7:0]              payload_byte_i,
    output logic                    payload_ready_o,
    output logic                    byte_valid_o,
    output logic [7:0]              byte_data_o,
    output logic                    byte_last_o,
    input  logic                    byte_ready_i,
    output logic                    frame_end_sent_o
);
    import csi_tx_pkg::*;

    localparam int PKT_BYTES = 4 + `WORD_COUNT;
    localparam int CNT_W     = $clog2(PKT_BYTES);

    logic             in_packet;
    logic [CNT_W-1:0] cnt;
    csi_header_u      hdr;
    logic             hdr_long;
    logic             in_header;
    logic             is_last;
    logic             header_xfer;
    logic             byte_xfer;

    assign in_header   = (cnt < CNT_W'(4));
    assign is_last     = hdr_long ? (cnt == CNT_W'(PKT_BYTES - 1)) : (cnt == CNT_W'(3));
    assign header_xfer = header_valid_i && header_ready_o;
    assign byte_xfer   = byte_valid_o && byte_ready_i;

    assign header_ready_o  = !in_packet;
    assign byte_valid_o    = in_packet && (in_header || payload_valid_i);
    assign payload_ready_o = in_packet && !in_header && byte_ready_i;
    assign byte_last_o     = in_packet && is_last;

    // frame end is the only short packet with data type 0x01
    assign frame_end_sent_o = byte_xfer && is_last && !hdr_long &&
                              (hdr.short_view.data_id[5:0] == `DT_FRAME_END);

    always_comb begin
        case (cnt)
            CNT_W'(0): byte_data_o = hdr.short_view.data_id;
            CNT_W'(1): byte_data_o = hdr.short_view.frame_number[7:0];  // or wc low
            CNT_W'(2): byte_data_o = hdr.short_view.frame_number[15:8];
            CNT_W'(3): byte_data_o = hdr.short_view.ecc;
            default:   byte_data_o = payload_byte_i;
        endcase
    end

    always_ff @(posedge clock_camera_byte) begin
        if (header_xfer) begin
            hdr      <= header_word_i;
            hdr_long <= header_long_i;
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            in_packet <= 1'b0;
            cnt       <= '0;
        end else begin
            if (header_xfer) begin
                in_packet <= 1'b1;
                cnt       <= '0;
            end else if (byte_xfer) begin
                if (is_last) begin
                    in_packet <= 1'b0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/csi_tx_top.sv
/*
 * byte clock transmit path top level
 * colour bar source, RAW10 packer, header builder and framer
 */
module csi_tx_top (
    input  logic       clock_camera_byte,
    input  logic       reset_camera_byte_n,
    input  logic       start_i,
    output logic       busy_o,
    output logic       frame_done_o,
    output logic       byte_valid_o,
    output logic [7:0] byte_data_o,
    output logic       byte_last_o,
    input  logic       byte_ready_i
);
    import csi_tx_pkg::*;

    logic        event_valid;
    logic        event_ready;
    csi_event_e  event_kind;
    logic        pixel_valid;
    logic        pixel_ready;
    logic [9:0]  pixel_data;
    logic        header_valid;
    logic        header_ready;
    csi_header_u header_word;
    logic        header_long;
    logic        payload_valid;
    logic        payload_ready;
    logic [7:0]  payload_byte;
    logic        frame_end_sent;

    colorbar_source u_source (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .start_i             (start_i),
        .busy_o              (busy_o),
        .frame_done_o        (frame_done_o),
        .event_valid_o       (event_valid),
        .event_kind_o        (event_kind),
        .event_ready_i       (event_ready),
        .pixel_valid_o       (pixel_valid),
        .pixel_data_o        (pixel_data),
        .pixel_ready_i       (pixel_ready),
        .frame_end_sent_i    (frame_end_sent)
    );

    raw10_packer u_packer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_valid_i       (pixel_valid),
        .pixel_data_i        (pixel_data),
        .pixel_ready_o       (pixel_ready),
        .payload_valid_o     (payload_valid),
        .payload_byte_o      (payload_byte),
        .payload_ready_i     (payload_ready)
    );

    packet_header_gen u_header (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .event_valid_i       (event_valid),
        .event_kind_i        (event_kind),
        .event_ready_o       (event_ready),
        .header_valid_o      (header_valid),
        .header_word_o       (header_word),
        .header_long_o       (header_long),
        .header_ready_i      (header_ready)
    );

    csi_packet_framer u_framer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .header_valid_i      (header_valid),
        .header_word_i       (header_word),
        .header_long_i       (header_long),
        .header_ready_o      (header_ready),
        .payload_valid_i     (payload_valid),
        .payload_byte_i      (payload_byte),
        .payload_ready_o     (payload_ready),
        .byte_valid_o        (byte_valid_o),
        .byte_data_o         (byte_data_o),
        .byte_last_o         (byte_last_o),
        .byte_ready_i        (byte_ready_i),
        .frame_end_sent_o    (frame_end_sent)
    );

endmodule

//--- test/csi_tx_model.svh
/*
 * reference model of the transmit byte stream
 * CSI-2 header ECC, Bayer colour bar pixels, RAW10 packing
 * and the expected byte, last and frame done queues of one frame
 */
`ifndef CSI_TX_MODEL_SVH
`define CSI_TX_MODEL_SVH

// parity bits p5..p0 touched by each header bit d0..d23
localparam logic [5:0] ECC_COLUMN [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
};

function automatic logic [7:0] model_ecc(input logic [23:0] hdr);
    logic [5:0] p;
    int         i;
    p = '0;
    for (i = 0; i < 24; i++) begin
        if (hdr[i]) p = p ^ ECC_COLUMN[i];
    end
    return {2'b00, p};
endfunction

function automatic logic [9:0] model_pixel(input int x, input int y);
    logic [29:0] rgb;
    case (x / `BAR_WIDTH)
        0:       rgb = `COLOR_BAR0;
        1:       rgb = `COLOR_BAR1;
        2:       rgb = `COLOR_BAR2;
        default: rgb = `COLOR_BAR3;
    endcase
    if (y % 2 == 1) return (x % 2 == 1) ? rgb[29:20] : rgb[19:10];  // r/g line
    return (x % 2 == 1) ? rgb[19:10] : rgb[9:0];                     // g/b line
endfunction

task automatic push_byte(input logic [7:0] b, input logic last, input logic done);
    exp_data.push_back(b);
    exp_last.push_back(last);
    exp_done.push_back(done);
endtask

task automatic push_header(input logic [5:0] dt, input logic [15:0] field,
                           input logic long_pkt, input logic frame_end);
    logic [23:0] h;
    h = {field, 2'b00, dt};  // vc 0
    push_byte(h[7:0], 1'b0, 1'b0);
    push_byte(h[15:8], 1'b0, 1'b0);
    push_byte(h[23:16], 1'b0, 1'b0);
    push_byte(model_ecc(h), !long_pkt, frame_end);
endtask

task automatic model_frame(input logic [15:0] frame_no);
    logic [9:0] px [4];
    int         y;
    int         g;
    int         k;
    push_header(`DT_FRAME_START, frame_no, 1'b0, 1'b0);
    for (y = 0; y < `IMAGE_Y_SIZE; y++) begin
        push_header(`DT_RAW10, 16'(`WORD_COUNT), 1'b1, 1'b0);
        for (g = 0; g < `IMAGE_X_SIZE / 4; g++) begin
            for (k = 0; k < 4; k++) begin
                px[k] = model_pixel(4 * g + k, y);
                push_byte(px[k][9:2], 1'b0, 1'b0);
            end
            push_byte({px[3][1:0], px[2][1:0], px[1][1:0], px[0][1:0]},
                      g == `IMAGE_X_SIZE / 4 - 1, 1'b0);
        end
    end
    push_header(`DT_FRAME_END, frame_no, 1'b0, 1'b1);
endtask

`endif

//--- test/csi_tx_tb.sv
/*
 * testbench for the byte clock CSI-2 transmit path
 * clock and reset, LFSR back-pressure and start gaps,
 * byte by byte comparison with the reference model, test report
 */
`include "csi_tx_defines.svh"

module csi_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_TIMEOUT = 4000;  // cycles
    localparam int FRAME_BYTES   = (`IMAGE_Y_SIZE + 2) * 4 + `IMAGE_Y_SIZE * `WORD_COUNT;

    logic       clock_camera_byte;
    logic       reset_camera_byte_n;
    logic       start_i;
    logic       busy_o;
    logic       frame_done_o;
    logic       byte_valid_o;
    logic [7:0] byte_data_o;
    logic       byte_last_o;
    logic       byte_ready_i;

    logic [7:0]  exp_data [$];
    logic        exp_last [$];
    logic        exp_done [$];
    logic [15:0] lfsr;
    logic [7:0]  ready_bits;
    logic        backpressure;
    logic        done_seen;  // frame_done_o on the previous edge
    int          data_errors;
    int          last_errors;
    int          done_errors;
    int          other_errors;
    int          done_count;
    int          last_count;
    int          byte_count;
    int          frames_run;
    int          tests_failed;
    int          base;
    int          i;

    `include "csi_tx_model.svh"

    csi_tx_top uut (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .start_i             (start_i),
        .busy_o              (busy_o),
        .frame_done_o        (frame_done_o),
        .byte_valid_o        (byte_valid_o),
        .byte_data_o         (byte_data_o),
        .byte_last_o         (byte_last_o),
        .byte_ready_i        (byte_ready_i)
    );

    always #20 clock_camera_byte = ~clock_camera_byte;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        int         k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return data_errors + last_errors + done_errors + other_errors;
    endfunction

    always @(negedge clock_camera_byte) begin
        if (backpressure) begin
            ready_bits   = random_bits(1);
            byte_ready_i = ready_bits[0];
        end else begin
            byte_ready_i = 1'b1;
        end
    end

    always @(posedge clock_camera_byte) begin : monitor
        logic [7:0] d;
        logic       l;
        logic       dn;
        if (reset_camera_byte_n) begin
            if (byte_valid_o && byte_ready_i) begin
                byte_count++;
                if (byte_last_o) last_count++;
                if (exp_data.size() == 0) begin
                    $display("t=%0t: byte %h sent when no byte was expected", $time, byte_data_o);
                    other_errors++;
                end else begin
                    d  = exp_data.pop_front();
                    l  = exp_last.pop_front();
                    dn = exp_done.pop_front();
                    if (byte_data_o !== d) begin
                        $display("[FAIL] t=%0t byte_data_o expected %h got %h", $time, d, byte_data_o);
                        data_errors++;
                    end
                    if (byte_last_o !== l) begin
                        $display("[FAIL] t=%0t byte_last_o expected %b got %b", $time, l, byte_last_o);
                        last_errors++;
                    end
                    if (frame_done_o !== dn) begin
                        $display("[FAIL] t=%0t frame_done_o expected %b got %b", $time, dn,
                                 frame_done_o);
                        done_errors++;
                    end
                end
                if (busy_o !== 1'b1) begin
                    $display("[FAIL] t=%0t busy_o expected 1 got %b", $time, busy_o);
                    done_errors++;
                end
            end else if (frame_done_o !== 1'b0) begin
                $display("[FAIL] t=%0t frame_done_o expected 0 got %b", $time, frame_done_o);
                done_errors++;
            end
            if (done_seen && busy_o !== 1'b0) begin
                $display("[FAIL] t=%0t busy_o expected 0 got %b", $time, busy_o);
                done_errors++;
            end
            if (frame_done_o) done_count++;
            done_seen = frame_done_o;
        end
    end

    task automatic apply_reset();
        @(negedge clock_camera_byte);
        reset_camera_byte_n = 1'b0;
        repeat (2) @(negedge clock_camera_byte);
        reset_camera_byte_n = 1'b1;
    endtask

    task automatic run_frame(input logic [15:0] frame_no, input logic poke_start);
        logic [7:0] gap;
        int         cycles;
        int         base_done;
        @(posedge clock_camera_byte);
        gap = random_bits(3);
        model_frame(frame_no);
        base_done = done_count;
        repeat (int'(gap) + 1) @(negedge clock_camera_byte);
        start_i = 1'b1;
        @(negedge clock_camera_byte);
        start_i = 1'b0;
        if (poke_start) begin
            repeat (10) @(negedge clock_camera_byte);
            if (busy_o !== 1'b1) begin
                $display("[FAIL] t=%0t busy_o expected 1 got %b", $time, busy_o);
                done_errors++;
            end
            start_i = 1'b1;  // mid frame, has no effect
            @(negedge clock_camera_byte);
            start_i = 1'b0;
        end
        cycles = 0;
        while (done_count == base_done && cycles < FRAME_TIMEOUT) begin
            @(negedge clock_camera_byte);
            cycles++;
        end
        if (done_count == base_done) begin
            $display("timeout: frame %0d did not finish within %0d cycles", frame_no,
                     FRAME_TIMEOUT);
            other_errors++;
            exp_data.delete();
            exp_last.delete();
            exp_done.delete();
        end else begin
            frames_run++;
            if (exp_data.size() != 0) begin
                $display("frame %0d ended with %0d expected bytes never sent", frame_no,
                         exp_data.size());
                other_errors++;
            end
            repeat (4) begin
                @(negedge clock_camera_byte);
                if (busy_o !== 1'b0 || byte_valid_o !== 1'b0) begin
                    $display("t=%0t: DUT became active again without a start", $time);
                    done_errors++;
                end
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        clock_camera_byte   = 1'b0;
        reset_camera_byte_n = 1'b0;
        start_i             = 1'b0;
        byte_ready_i        = 1'b0;
        backpressure        = 1'b0;
        done_seen           = 1'b0;
        lfsr                = 16'd98;
        data_errors  = 0;
        last_errors  = 0;
        done_errors  = 0;
        other_errors = 0;
        done_count   = 0;
        last_count   = 0;
        byte_count   = 0;
        frames_run   = 0;
        tests_failed = 0;
        apply_reset();

        base = total_errors();
        for (i = 0; i < 4; i++) begin
            @(posedge clock_camera_byte);
            if (byte_valid_o !== 1'b0) begin
                $display("[FAIL] t=%0t byte_valid_o expected 0 got %b", $time, byte_valid_o);
                other_errors++;
            end
            if (busy_o !== 1'b0) begin
                $display("[FAIL] t=%0t busy_o expected 0 got %b", $time, busy_o);
                other_errors++;
            end
            if (frame_done_o !== 1'b0) begin
                $display("[FAIL] t=%0t frame_done_o expected 0 got %b", $time, frame_done_o);
                other_errors++;
            end
        end
        report_test(1, "idle after reset", total_errors() - base);

        base = total_errors();
        run_frame(16'd1, 1'b0);
        report_test(2, "one frame, ready held high", total_errors() - base);

        base = total_errors();
        apply_reset();  // frame numbers restart at 1
        backpressure = 1'b1;
        byte_count   = 0;
        run_frame(16'd1, 1'b0);
        run_frame(16'd2, 1'b1);
        run_frame(16'd3, 1'b0);
        backpressure = 1'b0;
        if (byte_count != 3 * FRAME_BYTES) begin
            $display("sent %0d bytes in three frames instead of %0d", byte_count,
                     3 * FRAME_BYTES);
            other_errors++;
        end
        report_test(3, "three frames under back-pressure", total_errors() - base);

        if (last_count != frames_run * (`IMAGE_Y_SIZE + 2)) begin
            $display("saw %0d last markers instead of %0d", last_count,
                     frames_run * (`IMAGE_Y_SIZE + 2));
            last_errors++;
        end
        report_test(4, "last marker placement", last_errors);

        if (done_count != frames_run) begin
            $display("saw %0d frame done pulses for %0d frames", done_count, frames_run);
            done_errors++;
        end
        report_test(5, "frame done, busy and ignored start", done_errors);

        $display("%0d of 5 tests passed, %0d errors", 5 - tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- csi_tx_top.f
+incdir+logic
+incdir+test
logic/csi_tx_pkg.sv
logic/colorbar_source.sv
logic/raw10_packer.sv
logic/packet_header_gen.sv
logic/csi_packet_framer.sv
logic/csi_tx_top.sv
test/csi_tx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the csi_tx testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f csi_tx_top.f --top-module csi_tx_tb -o csi_tx_sim

./obj_dir/csi_tx_sim | tee "$LOG"

if grep -qx "TEST PASS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
